//--- Makefile
# Verilator build and run of the vector scratchpad testbench
# Any variable below can be overridden on the command line

VERILATOR   ?= verilator
TOP         ?= bank_xor_tb
FILELIST    ?= sources.f
OBJ_DIR     ?= obj_dir
EXTRA_FLAGS ?=

VFLAGS = --binary --timing --assert -Wno-fatal \
	--top-module $(TOP) --Mdir $(OBJ_DIR) \
	-f $(FILELIST) $(EXTRA_FLAGS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR EXTRA_FLAGS"

# The simulator exit status carries pass or fail
test:
	$(VERILATOR) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/bank_xor_assertions.sv
//==========================================================================
// APB protocol and command timing checks, bound to the register block
// Read command timing assumes psel and penable held until completion
//==========================================================================
`include "bank_xor_config.svh"

module bank_xor_assertions (
	input logic                  i_clk,
	input logic                  i_arst_n,
	input logic                  i_psel,
	input logic                  i_penable,
	input logic                  i_pwrite,
	input logic [`BX_APB_AW-1:0] i_paddr,
	input logic [31:0]           i_pwdata,
	input logic                  i_pready,
	input logic                  i_wr_en,
	input logic                  i_rd_en
);
	timeunit 1ns;
	timeprecision 100ps;

	import bank_xor_pkg::*;

	localparam logic [`BX_APB_AW-1:0] ADDR_CMD = 'h8;

	// Op field of the CMD word on the bus
	cmd_op_t op;
	logic    rd_cmd;

	assign op     = cmd_op_t'(i_pwdata[`BX_ROW_BW +: 2]);
	assign rd_cmd = i_psel & i_penable & i_pwrite & (i_paddr == ADDR_CMD) &
		((op == CMD_READ) | (op == CMD_RAW));

	// Slave only answers inside a transfer
	a_pready_needs_psel: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_pready |-> i_psel)
		else $error("pready high while psel is low");

	// First access cycle of a read command, two wait states then completion
	a_read_cmd_three_cycles: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(rd_cmd && $rose(i_penable)) |-> !i_pready ##1 !i_pready ##1 i_pready)
		else $error("read command did not complete on its third access cycle");

	a_strobes_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_wr_en && i_rd_en))
		else $error("bank write and read strobes high together");

endmodule

bind bank_apb_regs bank_xor_assertions u_apb_assert (
	.i_clk     (i_clk),
	.i_arst_n  (i_arst_n),
	.i_psel    (i_psel),
	.i_penable (i_penable),
	.i_pwrite  (i_pwrite),
	.i_paddr   (i_paddr),
	.i_pwdata  (i_pwdata),
	.i_pready  (o_pready),
	.i_wr_en   (o_wr_en),
	.i_rd_en   (o_rd_en)
);

//--- dv/bank_xor_tb.sv
//==========================================================================
// Testbench for the XOR-swizzled vector scratchpad over APB3
// Expected bank order comes from a model of the lane permutation rules
// Geometry is the one in the config header, four 8-bit lanes
//==========================================================================
`include "bank_xor_config.svh"

module bank_xor_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import bank_xor_pkg::*;

	localparam int NUM_VEC    = 8;
	localparam int NUM_ALIAS  = 6;
	localparam int MAX_CYCLES = NUM_VEC * 40 + 100;

	localparam logic [`BX_APB_AW-1:0] A_CFG   = 'h0;
	localparam logic [`BX_APB_AW-1:0] A_WDATA = 'h4;
	localparam logic [`BX_APB_AW-1:0] A_CMD   = 'h8;
	localparam logic [`BX_APB_AW-1:0] A_RDATA = 'hC;
	// Holes in the register map
	localparam logic [`BX_APB_AW-1:0] A_HOLE0 = 'h2;
	localparam logic [`BX_APB_AW-1:0] A_HOLE1 = 'h6;

	// Stage 0 on row bit 1, stage 1 on row bit 3, swap on
	localparam logic [31:0] ALIAS_CFG = 32'h6B;

	logic                  clk;
	logic                  arst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`BX_APB_AW-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	integer seed;
	int     cycle_cnt;
	int     err_cnt;

	// Stimulus table, one vector per entry
	string       tname  [NUM_VEC];
	logic [31:0] tcfg   [NUM_VEC];
	row_t        trow   [NUM_VEC];
	logic [31:0] twdata [NUM_VEC];
	logic [31:0] texp   [NUM_VEC];

	// Rows for the aliasing pass
	row_t        alias_row  [NUM_ALIAS];
	logic [31:0] alias_data [NUM_ALIAS];

	bank_xor_top uut (
		.i_clk     (clk),
		.i_arst_n  (arst_n),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Some tests failed");
		$fatal(1, "Cycle limit reached");
	end

	//==========================================================================
	// Reference model
	//==========================================================================
	// Lane vector to bank order for one CFG word and row
	function automatic logic [31:0] bank_order(input logic [31:0] cfg, input row_t row,
		input logic [31:0] lanes);
		lane_t       cur [`BX_NBANK];
		lane_t       nxt [`BX_NBANK];
		logic [31:0] res;
		int          src;
		int          from;
		logic        sel;
		res = '0;
		for (int k = 0; k < `BX_NBANK; k++)
			cur[k] = lanes[k*`BX_DATA_BW +: `BX_DATA_BW];
		// Butterfly, LSB stage first
		for (int st = 0; st < `BX_CB_BW; st++) begin
			src = int'(cfg[st*`BX_XOR_BW +: `BX_XOR_BW]);
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (src == (1 << `BX_XOR_BW) - 1)
					sel = 1'b0;
				else if (src < `BX_CB_BW)
					sel = ((j >> src) & 1) == 1;
				else if (src - `BX_CB_BW < `BX_ROW_BW)
					sel = row[src - `BX_CB_BW];
				else
					sel = 1'b0;
				nxt[j] = sel ? cur[j ^ (1 << st)] : cur[j];
			end
			cur = nxt;
		end
		// Omega, bank j takes lane at j rotated right by 2^st
		for (int st = 0; st < `BX_CCB_BW; st++) begin
			if (cfg[`BX_CB_BW*`BX_XOR_BW + st]) begin
				for (int j = 0; j < `BX_NBANK; j++) begin
					from = ((j >> (1 << st)) | (j << (`BX_CB_BW - (1 << st)))) & (`BX_NBANK - 1);
					nxt[j] = cur[from];
				end
				cur = nxt;
			end
		end
		for (int k = 0; k < `BX_NBANK; k++)
			res[k*`BX_DATA_BW +: `BX_DATA_BW] = cur[k];
		return res;
	endfunction

	function automatic logic [31:0] cmd_word(input cmd_op_t op, input row_t row);
		return {{(32 - 2 - `BX_ROW_BW){1'b0}}, op, row};
	endfunction

	task automatic set_entry(input int idx, input string name, input logic [31:0] cfg,
		input row_t row);
		tname[idx] = name;
		tcfg[idx]  = cfg;
		trow[idx]  = row;
	endtask

	task automatic fill_table();
		// Sources 7 off, 0 and 1 lane bits, 2 to 5 row bits
		set_entry(0, "identity",      32'h3F, 4'd3);
		set_entry(1, "swap only",     32'h7F, 4'd5);
		set_entry(2, "s0 lane bit 1", 32'h39, 4'd2);
		set_entry(3, "s1 lane bit 0", 32'h07, 4'd9);
		set_entry(4, "s0 row bit 0a", 32'h3A, 4'd6);
		set_entry(5, "s0 row bit 0b", 32'h3A, 4'd7);
		set_entry(6, "row bits swap", 32'h6B, 4'd10);
		set_entry(7, "mixed swap",    32'h61, 4'd12);
		for (int i = 0; i < NUM_VEC; i++)
			twdata[i] = $random(seed);
		// Same data on both rows of one CFG so only the row bit differs
		twdata[5] = twdata[4];
		for (int i = 0; i < NUM_VEC; i++)
			texp[i] = bank_order(tcfg[i], trow[i], twdata[i]);
		alias_row[0] = 4'd1;
		alias_row[1] = 4'd2;
		alias_row[2] = 4'd4;
		alias_row[3] = 4'd8;
		alias_row[4] = 4'd0;
		alias_row[5] = 4'd15;
		for (int a = 0; a < NUM_ALIAS; a++)
			alias_data[a] = $random(seed);
	endtask

	//==========================================================================
	// APB tasks and checks
	//==========================================================================
	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			err_cnt++;
			$display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
			$display("Some tests failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// One transfer, inputs change on the falling edge
	task automatic apb_xfer(input logic wr, input logic [`BX_APB_AW-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int ncyc);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		ncyc    = 0;
		// Completion sampled at the rising edge
		do begin
			@(posedge clk);
			ncyc++;
			rdata = prdata;
			err   = pslverr;
		end while (!pready);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_check(input string name, input logic [`BX_APB_AW-1:0] addr,
		input logic [31:0] data, input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		int          ncyc;
		apb_xfer(1'b1, addr, data, rdata, err, ncyc);
		check_value({name, " pslverr"}, {31'd0, exp_err}, {31'd0, err});
		check_value({name, " access cycles"}, 32'd1, ncyc);
	endtask

	task automatic read_check(input string name, input logic [`BX_APB_AW-1:0] addr,
		input logic [31:0] exp_data);
		logic [31:0] rdata;
		logic        err;
		int          ncyc;
		apb_xfer(1'b0, addr, 32'd0, rdata, err, ncyc);
		check_value({name, " pslverr"}, 32'd0, {31'd0, err});
		check_value({name, " access cycles"}, 32'd1, ncyc);
		check_value(name, exp_data, rdata);
	endtask

	// Read and raw hold two wait states, write completes at once
	task automatic run_cmd(input string name, input cmd_op_t op, input row_t row);
		logic [31:0] rdata;
		logic        err;
		int          ncyc;
		int          exp_cyc;
		exp_cyc = (op == CMD_READ || op == CMD_RAW) ? 3 : 1;
		apb_xfer(1'b1, A_CMD, cmd_word(op, row), rdata, err, ncyc);
		check_value({name, " pslverr"}, 32'd0, {31'd0, err});
		check_value({name, " access cycles"}, exp_cyc, ncyc);
	endtask

	//==========================================================================
	// Test sequence
	//==========================================================================
	initial begin
		logic [31:0] rdata;
		logic        err;
		int          ncyc;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		arst_n  = 1'b0;
		err_cnt = 0;
		seed    = 32'he78;
		fill_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Reset values, sources all-ones and RDATA cleared
		read_check("reset rdata", A_RDATA, 32'h0);
		read_check("reset cfg", A_CFG, 32'h3F);

		// Round trip and bank placement per table entry
		for (int i = 0; i < NUM_VEC; i++) begin
			write_check({tname[i], " cfg"}, A_CFG, tcfg[i], 1'b0);
			read_check({tname[i], " cfg readback"}, A_CFG, tcfg[i]);
			write_check({tname[i], " wdata"}, A_WDATA, twdata[i], 1'b0);
			run_cmd({tname[i], " write cmd"}, CMD_WRITE, trow[i]);
			run_cmd({tname[i], " read cmd"}, CMD_READ, trow[i]);
			read_check({tname[i], " round trip"}, A_RDATA, twdata[i]);
			run_cmd({tname[i], " raw cmd"}, CMD_RAW, trow[i]);
			read_check({tname[i], " bank order"}, A_RDATA, texp[i]);
		end

		// Fill several rows then read back in reverse
		write_check("alias cfg", A_CFG, ALIAS_CFG, 1'b0);
		for (int a = 0; a < NUM_ALIAS; a++) begin
			write_check($sformatf("alias wdata %0d", a), A_WDATA, alias_data[a], 1'b0);
			run_cmd($sformatf("alias write row %0d", alias_row[a]), CMD_WRITE, alias_row[a]);
		end
		for (int a = NUM_ALIAS - 1; a >= 0; a--) begin
			run_cmd($sformatf("alias read row %0d", alias_row[a]), CMD_READ, alias_row[a]);
			read_check($sformatf("alias row %0d", alias_row[a]), A_RDATA, alias_data[a]);
		end

		// Error responses leave the registers alone
		write_check("illegal cfg stage 0", A_CFG, 32'h38, 1'b1);
		read_check("cfg after illegal stage 0", A_CFG, ALIAS_CFG);
		write_check("illegal cfg stage 1", A_CFG, 32'h0F, 1'b1);
		read_check("cfg after illegal stage 1", A_CFG, ALIAS_CFG);
		write_check("unmapped write", A_HOLE0, 32'h7F, 1'b1);
		read_check("cfg after unmapped write", A_CFG, ALIAS_CFG);
		apb_xfer(1'b0, A_HOLE1, 32'd0, rdata, err, ncyc);
		check_value("unmapped read pslverr", 32'd1, {31'd0, err});
		check_value("unmapped read access cycles", 32'd1, ncyc);
		write_check("rdata write", A_RDATA, 32'hDEAD_BEEF, 1'b1);
		read_check("rdata after write", A_RDATA, alias_data[0]);
		read_check("cfg after rdata write", A_CFG, ALIAS_CFG);

		if (err_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "Checks reported errors");
		end
	end

endmodule

//--- sources.f
+incdir+verilog
verilog/bank_xor_pkg.sv
verilog/bank_butterfly_write.sv
verilog/bank_sram_array.sv
verilog/bank_butterfly_read.sv
verilog/bank_apb_regs.sv
verilog/bank_xor_top.sv
dv/bank_xor_assertions.sv
dv/bank_xor_tb.sv

//--- verilog/bank_apb_regs.sv
//==========================================================================
// APB3 register block, one outstanding vector command at a time
// Write command completes in 1 access cycle, read and raw in exactly 3
// CFG writes that would not form a permutation are refused with pslverr
// Lane k of WDATA and RDATA sits in bits 8k+7:8k
//==========================================================================
`include "bank_xor_config.svh"

module bank_apb_regs (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`BX_APB_AW-1:0]  i_paddr,
	input  logic [31:0]            i_pwdata,
	output logic [31:0]            o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	output bank_xor_pkg::xor_src_t o_xor_src [`BX_CB_BW],
	output bank_xor_pkg::swap_t    o_swap,
	output bank_xor_pkg::row_t     o_row,
	output bank_xor_pkg::lane_t    o_wdata [`BX_NBANK],
	output logic                   o_wr_en,
	output logic                   o_rd_en,
	output logic                   o_raw,
	input  bank_xor_pkg::lane_t    i_rdata [`BX_NBANK]
);

	import bank_xor_pkg::*;

	//==========================================================================
	// Register map
	//==========================================================================
	localparam logic [`BX_APB_AW-1:0] ADDR_CFG   = 'h0;
	localparam logic [`BX_APB_AW-1:0] ADDR_WDATA = 'h4;
	localparam logic [`BX_APB_AW-1:0] ADDR_CMD   = 'h8;
	localparam logic [`BX_APB_AW-1:0] ADDR_RDATA = 'hC;
	// Swap bit follows the source fields in CFG
	localparam int SWAP_LSB = `BX_CB_BW * `BX_XOR_BW;
	// Op field follows the row in CMD
	localparam int OP_LSB = `BX_ROW_BW;

	// Access decode
	logic        access;
	logic        hit_cfg;
	logic        hit_wdata;
	logic        hit_cmd;
	logic        hit_rdata;
	logic        unmapped;
	logic        cfg_bad;
	logic        err;
	logic        rd_start;
	logic        commit;
	cmd_op_t     wr_op;
	row_t        wr_row;
	logic [31:0] rd_mux;

	// Read command FSM
	apb_state_t state;
	apb_state_t state_nxt;

	// Registers
	xor_src_t cfg_src [`BX_CB_BW];
	swap_t    cfg_swap;
	lane_t    wdata_q [`BX_NBANK];
	row_t     cmd_row;
	cmd_op_t  cmd_op;
	lane_t    rdata_q [`BX_NBANK];

	//==========================================================================
	// Decode
	//==========================================================================
	assign access    = i_psel & i_penable;
	assign hit_cfg   = (i_paddr == ADDR_CFG);
	assign hit_wdata = (i_paddr == ADDR_WDATA);
	assign hit_cmd   = (i_paddr == ADDR_CMD);
	assign hit_rdata = (i_paddr == ADDR_RDATA);
	assign unmapped  = ~(hit_cfg | hit_wdata | hit_cmd | hit_rdata);

	// CMD fields straight from the bus, held stable by the master
	assign wr_op  = cmd_op_t'(i_pwdata[OP_LSB +: 2]);
	assign wr_row = i_pwdata[`BX_ROW_BW-1:0];

	// Stage i sourced from lane bit i would map two lanes to one bank
	always_comb begin
		cfg_bad = 1'b0;
		for (int i = 0; i < `BX_CB_BW; i++) begin
			if (i_pwdata[i*`BX_XOR_BW +: `BX_XOR_BW] == xor_src_t'(i))
				cfg_bad = 1'b1;
		end
	end

	assign err = unmapped | (i_pwrite & hit_rdata) | (i_pwrite & hit_cfg & cfg_bad);

	// Read or raw command entering its first access cycle
	assign rd_start = access & i_pwrite & hit_cmd & (state == ST_IDLE) &
		((wr_op == CMD_READ) | (wr_op == CMD_RAW));

	// Wait states only for read commands
	assign o_pready  = access & ~rd_start & (state != ST_WAIT);
	assign o_pslverr = o_pready & err;
	assign commit    = o_pready & i_pwrite & ~err;

	//==========================================================================
	// Command strobes to the datapath
	//==========================================================================
	// Banks take the row on the edge that ends the access
	assign o_wr_en = access & i_pwrite & hit_cmd & (state == ST_IDLE) & (wr_op == CMD_WRITE);
	assign o_rd_en = rd_start;
	// Raw flag must hold through the capture cycle
	assign o_raw   = access & i_pwrite & hit_cmd & (wr_op == CMD_RAW);
	// Row from the bus during a CMD access, stored row otherwise
	assign o_row   = (access & i_pwrite & hit_cmd) ? wr_row : cmd_row;

	assign o_xor_src = cfg_src;
	assign o_swap    = cfg_swap;
	assign o_wdata   = wdata_q;

	//==========================================================================
	// Read command FSM
	//==========================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (rd_start) state_nxt = ST_WAIT;
			// Bank output valid this cycle
			ST_WAIT: state_nxt = ST_DONE;
			// pready high, transfer ends
			ST_DONE: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	//==========================================================================
	// Registers
	//==========================================================================
	// Sources reset to all-ones, identity mapping
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `BX_CB_BW; i++) begin
				cfg_src[i] <= '1;
			end
			cfg_swap <= '0;
			cmd_row  <= '0;
			cmd_op   <= CMD_NONE;
		end else if (commit) begin
			if (hit_cfg) begin
				for (int i = 0; i < `BX_CB_BW; i++) begin
					cfg_src[i] <= i_pwdata[i*`BX_XOR_BW +: `BX_XOR_BW];
				end
				cfg_swap <= i_pwdata[SWAP_LSB +: `BX_CCB_BW];
			end
			if (hit_cmd) begin
				cmd_row <= wr_row;
				cmd_op  <= wr_op;
			end
		end
	end

	// Write vector staging
	always_ff @(posedge i_clk) begin
		if (commit && hit_wdata) begin
			for (int k = 0; k < `BX_NBANK; k++) begin
				wdata_q[k] <= i_pwdata[k*`BX_DATA_BW +: `BX_DATA_BW];
			end
		end
	end

	// Returned vector, captured in the wait cycle
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int k = 0; k < `BX_NBANK; k++) begin
				rdata_q[k] <= '0;
			end
		end else if (state == ST_WAIT) begin
			rdata_q <= i_rdata;
		end
	end

	//==========================================================================
	// Read data
	//==========================================================================
	always_comb begin
		rd_mux = '0;
		if (hit_cfg) begin
			for (int i = 0; i < `BX_CB_BW; i++) begin
				rd_mux[i*`BX_XOR_BW +: `BX_XOR_BW] = cfg_src[i];
			end
			rd_mux[SWAP_LSB +: `BX_CCB_BW] = cfg_swap;
		end else if (hit_wdata) begin
			for (int k = 0; k < `BX_NBANK; k++) begin
				rd_mux[k*`BX_DATA_BW +: `BX_DATA_BW] = wdata_q[k];
			end
		end else if (hit_cmd) begin
			rd_mux[`BX_ROW_BW-1:0] = cmd_row;
			rd_mux[OP_LSB +: 2]    = cmd_op;
		end else if (hit_rdata) begin
			for (int k = 0; k < `BX_NBANK; k++) begin
				rd_mux[k*`BX_DATA_BW +: `BX_DATA_BW] = rdata_q[k];
			end
		end
	end

	// Bus idles at zero outside read transfers
	assign o_prdata = (i_psel & ~i_pwrite) ? rd_mux : '0;

endmodule

//--- verilog/bank_butterfly_read.sv
//==========================================================================
// Read network, banks back into lane order, purely combinational
// Undoes the write network for the same CFG and row
// Raw mode returns bank order untouched
//==========================================================================
`include "bank_xor_config.svh"

module bank_butterfly_read (
	input  bank_xor_pkg::xor_src_t i_xor_src [`BX_CB_BW],
	input  bank_xor_pkg::swap_t    i_swap,
	input  bank_xor_pkg::row_t     i_row,
	input  logic                   i_raw,
	input  bank_xor_pkg::lane_t    i_data [`BX_NBANK],
	output bank_xor_pkg::lane_t    o_data [`BX_NBANK]
);

	import bank_xor_pkg::*;

	localparam int NSTAGE    = `BX_CB_BW + `BX_CCB_BW;
	localparam int BANK_MASK = `BX_NBANK - 1;

	// Same selects as the write side
	logic [`BX_CB_BW-1:0] row_sel;
	logic [`BX_CB_BW-1:0] lane_sel [`BX_NBANK];
	// Data between stages, omega first then butterfly
	lane_t stage_data [NSTAGE+1][`BX_NBANK];

	//==========================================================================
	// Stage selects
	//==========================================================================
	always_comb begin
		int src;
		int row_bit;
		for (int i = 0; i < `BX_CB_BW; i++) begin
			src     = int'(i_xor_src[i]);
			row_bit = src - `BX_CB_BW;
			row_sel[i] = (row_bit >= 0 && row_bit < `BX_ROW_BW) ? i_row[row_bit] : 1'b0;
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (&i_xor_src[i])
					lane_sel[j][i] = 1'b0;
				else if (src < `BX_CB_BW)
					lane_sel[j][i] = ((j >> src) & 1) != 0;
				else
					lane_sel[j][i] = row_sel[i];
			end
		end
	end

	//==========================================================================
	// Inverse omega then inverse butterfly
	//==========================================================================
	always_comb begin
		int i;
		stage_data[0] = i_data;
		// Last omega stage first, rotate left by 2^i
		for (int k = 0; k < `BX_CCB_BW; k++) begin
			i = `BX_CCB_BW - 1 - k;
			for (int j = 0; j < `BX_NBANK; j++) begin
				stage_data[k+1][j] = i_swap[i] ?
					stage_data[k][((j | (j << `BX_CB_BW)) >> (`BX_CB_BW - (1 << i))) & BANK_MASK] :
					stage_data[k][j];
			end
		end
		// Butterfly MSB to LSB, each stage is its own inverse
		for (int k = 0; k < `BX_CB_BW; k++) begin
			i = `BX_CB_BW - 1 - k;
			for (int j = 0; j < `BX_NBANK; j++) begin
				stage_data[`BX_CCB_BW+k+1][j] = lane_sel[j][i] ?
					stage_data[`BX_CCB_BW+k][j ^ (1 << i)] : stage_data[`BX_CCB_BW+k][j];
			end
		end
	end

	assign o_data = i_raw ? i_data : stage_data[NSTAGE];

endmodule

//--- verilog/bank_butterfly_write.sv
//==========================================================================
// Write network, lanes into banks, purely combinational
// Butterfly stages run LSB first, then omega stages
// Stage i must not take lane bit i as its source
//==========================================================================
`include "bank_xor_config.svh"

module bank_butterfly_write (
	input  bank_xor_pkg::xor_src_t i_xor_src [`BX_CB_BW],
	input  bank_xor_pkg::swap_t    i_swap,
	input  bank_xor_pkg::row_t     i_row,
	input  bank_xor_pkg::lane_t    i_data [`BX_NBANK],
	output bank_xor_pkg::lane_t    o_data [`BX_NBANK]
);

	import bank_xor_pkg::*;

	localparam int NSTAGE    = `BX_CB_BW + `BX_CCB_BW;
	localparam int BANK_MASK = `BX_NBANK - 1;

	// Per-stage select from a row bit
	logic [`BX_CB_BW-1:0] row_sel;
	// Per-lane, per-stage select
	logic [`BX_CB_BW-1:0] lane_sel [`BX_NBANK];
	// Data between stages, entry 0 is the input
	lane_t stage_data [NSTAGE+1][`BX_NBANK];

	//==========================================================================
	// Stage selects
	//==========================================================================
	always_comb begin
		int src;
		int row_bit;
		for (int i = 0; i < `BX_CB_BW; i++) begin
			src     = int'(i_xor_src[i]);
			row_bit = src - `BX_CB_BW;
			// Row bits past the address width read as 0
			row_sel[i] = (row_bit >= 0 && row_bit < `BX_ROW_BW) ? i_row[row_bit] : 1'b0;
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (&i_xor_src[i])
					lane_sel[j][i] = 1'b0;
				else if (src < `BX_CB_BW)
					lane_sel[j][i] = ((j >> src) & 1) != 0;
				else
					lane_sel[j][i] = row_sel[i];
			end
		end
	end

	//==========================================================================
	// Butterfly then omega
	//==========================================================================
	always_comb begin
		stage_data[0] = i_data;
		// Lane j swaps with its partner across bit i
		for (int i = 0; i < `BX_CB_BW; i++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				stage_data[i+1][j] = lane_sel[j][i] ?
					stage_data[i][j ^ (1 << i)] : stage_data[i][j];
			end
		end
		// Output j takes input at j rotated right by 2^i
		for (int i = 0; i < `BX_CCB_BW; i++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				stage_data[`BX_CB_BW+i+1][j] = i_swap[i] ?
					stage_data[`BX_CB_BW+i][((j | (j << `BX_CB_BW)) >> (1 << i)) & BANK_MASK] :
					stage_data[`BX_CB_BW+i][j];
			end
		end
	end

	assign o_data = stage_data[NSTAGE];

endmodule

//--- verilog/bank_sram_array.sv
//==========================================================================
// Bank array, one single-port row memory per bank
// Whole row written at once, read data valid one clock after i_rd_en
// Contents are undefined until written
//==========================================================================
`include "bank_xor_config.svh"

module bank_sram_array (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  logic                i_wr_en,
	input  logic                i_rd_en,
	input  bank_xor_pkg::row_t  i_row,
	input  bank_xor_pkg::lane_t i_wdata [`BX_NBANK],
	output bank_xor_pkg::lane_t o_rdata [`BX_NBANK]
);

	import bank_xor_pkg::*;

	localparam int NROW = 1 << `BX_ROW_BW;

	// Bank storage, first index is the bank
	lane_t mem [`BX_NBANK][NROW];

	// Row write, every bank at the same address
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			for (int b = 0; b < `BX_NBANK; b++) begin
				mem[b][i_row] <= i_wdata[b];
			end
		end
	end

	// Registered read port, holds its value between reads
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int b = 0; b < `BX_NBANK; b++) begin
				o_rdata[b] <= '0;
			end
		end else if (i_rd_en) begin
			for (int b = 0; b < `BX_NBANK; b++) begin
				o_rdata[b] <= mem[b][i_row];
			end
		end
	end

endmodule

//--- verilog/bank_xor_config.svh
//==========================================================================
// Geometry of the XOR-swizzled vector scratchpad
// BX_NBANK must equal 2**BX_CB_BW and one vector must fit in 32 APB bits
// Only the geometry below is exercised
//==========================================================================
`ifndef BANK_XOR_CONFIG_SVH
`define BANK_XOR_CONFIG_SVH

// Width of one data lane
`define BX_DATA_BW 8

// Bank count, one lane per bank
`define BX_NBANK 4

// Butterfly stages, also the bank index width
`define BX_CB_BW 2

// Omega stages
`define BX_CCB_BW 1

// Width of one XOR source field, all-ones disables the stage
`define BX_XOR_BW 3

// Row address width, gives 16 rows per bank
`define BX_ROW_BW 4

// APB byte address width
`define BX_APB_AW 4

`endif

//--- verilog/bank_xor_pkg.sv
//==========================================================================
// Shared types of the vector scratchpad
// All widths come from the config header
//==========================================================================
`include "bank_xor_config.svh"

package bank_xor_pkg;

	// One vector lane
	typedef logic [`BX_DATA_BW-1:0] lane_t;

	// Bank or lane index
	typedef logic [`BX_CB_BW-1:0] bank_idx_t;

	// Stage select source
	// All-ones is no swap, below BX_CB_BW is a lane bit, else a row bit
	typedef logic [`BX_XOR_BW-1:0] xor_src_t;

	// Omega stage enables
	typedef logic [`BX_CCB_BW-1:0] swap_t;

	// Row address inside every bank
	typedef logic [`BX_ROW_BW-1:0] row_t;

	// Vector command carried in CMD bits 5:4
	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_WRITE,
		CMD_READ,
		CMD_RAW
	} cmd_op_t;

	// Read command sequencing on the APB side
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_DONE
	} apb_state_t;

endpackage

//--- verilog/bank_xor_top.sv
//==========================================================================
// Vector scratchpad top, APB3 slave in front of the swizzled banks
// Single clock, single outstanding command
//==========================================================================
`include "bank_xor_config.svh"

module bank_xor_top (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [`BX_APB_AW-1:0] i_paddr,
	input  logic [31:0]           i_pwdata,
	output logic [31:0]           o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr
);

	import bank_xor_pkg::*;

	// Configuration and command from the register block
	xor_src_t xor_src [`BX_CB_BW];
	swap_t    swap;
	row_t     row;
	logic     wr_en;
	logic     rd_en;
	logic     raw;

	// Vectors in lane order and in bank order
	lane_t lane_wdata [`BX_NBANK];
	lane_t bank_wdata [`BX_NBANK];
	lane_t bank_rdata [`BX_NBANK];
	lane_t lane_rdata [`BX_NBANK];

	// Producer of vector commands
	bank_apb_regs u_regs (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_xor_src (xor_src),
		.o_swap    (swap),
		.o_row     (row),
		.o_wdata   (lane_wdata),
		.o_wr_en   (wr_en),
		.o_rd_en   (rd_en),
		.o_raw     (raw),
		.i_rdata   (lane_rdata)
	);

	// Lanes into banks
	bank_butterfly_write u_wr_net (
		.i_xor_src (xor_src),
		.i_swap    (swap),
		.i_row     (row),
		.i_data    (lane_wdata),
		.o_data    (bank_wdata)
	);

	bank_sram_array u_banks (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_wr_en  (wr_en),
		.i_rd_en  (rd_en),
		.i_row    (row),
		.i_wdata  (bank_wdata),
		.o_rdata  (bank_rdata)
	);

	// Banks back into lanes, or bank order on raw reads
	bank_butterfly_read u_rd_net (
		.i_xor_src (xor_src),
		.i_swap    (swap),
		.i_row     (row),
		.i_raw     (raw),
		.i_data    (bank_rdata),
		.o_data    (lane_rdata)
	);

endmodule
